//--- source/tetris_ai_pkg.sv
`default_nettype none

package tetris_ai_pkg;

  // ====================
  // datapath widths
  // ====================
  localparam int FEAT_W       = 8;
  localparam int N_LAYERS     = 4;
  localparam int N_ACT        = 4;
  localparam int ACC_W        = 14;
  localparam int WEIGHT_SHIFT = 2;

  // board score weights, scaled by SCORE_DIV
  localparam int W_LINES   = 76;
  localparam int W_HEIGHT  = 50;
  localparam int W_HOLES   = 36;
  localparam int W_BUMP    = 18;
  localparam int SCORE_DIV = 100;

  // game fsm codes seen from outside
  typedef enum logic [3:0] {
    GS_INIT     = 4'd0,
    GS_RUN      = 4'd1,
    GS_GAMEOVER = 4'd8,
    GS_RESTART  = 4'd9
  } game_state_t;

  typedef enum logic [1:0] {
    MODE_IDLE,
    MODE_HUMAN,
    MODE_AI
  } play_mode_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_LAYER0,
    SEQ_LAYER1,
    SEQ_LAYER2,
    SEQ_LAYER3,
    SEQ_DONE
  } seq_state_t;

endpackage

`default_nettype wire

//--- source/play_mode_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module play_mode_arbiter
  import tetris_ai_pkg::*;
(
  input  wire logic        clk_25m,
  input  wire logic        rst,
  input  wire game_state_t gamestate_i,
  input  wire logic        start_ai_i,
  input  wire logic        start_human_i,
  input  wire logic        btn_right_i,
  input  wire logic        btn_left_i,
  input  wire logic        btn_rot_r_i,
  input  wire logic        btn_rot_l_i,
  input  wire logic        btn_fast_i,
  input  wire logic        ai_right_i,
  input  wire logic        ai_left_i,
  input  wire logic        ai_rotate_i,
  output logic             move_right_o,
  output logic             move_left_o,
  output logic             rot_r_o,
  output logic             rot_l_o,
  output logic             speed_up_o,
  output play_mode_t       play_mode_o
);

  play_mode_t mode_q;
  play_mode_t mode_d;

  // mode register
  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      mode_q <= MODE_IDLE;
    end else begin
      mode_q <= mode_d;
    end
  end

  assign play_mode_o = mode_q;

  // ====================
  // next mode and movement mux
  // ====================
  always_comb begin
    mode_d       = mode_q;
    move_right_o = 1'b0;
    move_left_o  = 1'b0;
    rot_r_o      = 1'b0;
    rot_l_o      = 1'b0;
    speed_up_o   = 1'b0;
    case (mode_q)
      MODE_IDLE: begin
        // right button kept alive so the game can leave gameover
        move_right_o = btn_right_i;
        if (gamestate_i == GS_INIT || gamestate_i == GS_RESTART) begin
          // ai has priority over human start
          if (start_ai_i) begin
            mode_d = MODE_AI;
          end else if (start_human_i) begin
            mode_d = MODE_HUMAN;
          end
        end
      end
      MODE_HUMAN: begin
        if (gamestate_i == GS_GAMEOVER) begin
          mode_d = MODE_IDLE;
        end else begin
          move_right_o = btn_right_i;
          move_left_o  = btn_left_i;
          rot_r_o      = btn_rot_r_i;
          rot_l_o      = btn_rot_l_i;
          speed_up_o   = btn_fast_i;
        end
      end
      MODE_AI: begin
        if (gamestate_i == GS_GAMEOVER) begin
          mode_d = MODE_IDLE;
        end else begin
          // engine only rotates one way, always drops fast
          move_right_o = ai_right_i;
          move_left_o  = ai_left_i;
          rot_r_o      = ai_rotate_i;
          speed_up_o   = 1'b1;
        end
      end
      default: begin
        mode_d = MODE_IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/feature_scorer.sv
`timescale 1ns/10ps
`default_nettype none

module feature_scorer
  import tetris_ai_pkg::*;
(
  input  wire logic              clk_25m,
  input  wire logic              rst,
  input  wire logic              extract_ready_i,
  input  wire logic [FEAT_W-1:0] lines_cleared_i,
  input  wire logic [FEAT_W-1:0] holes_i,
  input  wire logic [FEAT_W-1:0] bumpiness_i,
  input  wire logic [FEAT_W-1:0] height_sum_i,
  output logic      [FEAT_W-1:0] score_o,
  output logic                   score_valid_o
);

  // 255 * 180 needs 16 bits, one spare
  localparam int SUM_W = 17;

  logic [SUM_W-1:0] weighted_sum;
  logic [SUM_W-1:0] score_full;

  // weighted feature sum
  assign weighted_sum = SUM_W'(lines_cleared_i * W_LINES)
                      + SUM_W'(height_sum_i * W_HEIGHT)
                      + SUM_W'(holes_i * W_HOLES)
                      + SUM_W'(bumpiness_i * W_BUMP);

  // integer divide back to unit scale
  assign score_full = weighted_sum / SUM_W'(SCORE_DIV);

  // score capture, held until next strobe
  always_ff @(posedge clk_25m) begin
    if (extract_ready_i) begin
      // only low byte goes on
      score_o <= score_full[FEAT_W-1:0];
    end
  end

  // valid pulse one cycle after strobe
  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      score_valid_o <= 1'b0;
    end else begin
      score_valid_o <= extract_ready_i;
    end
  end

endmodule

`default_nettype wire

//--- source/layer_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module layer_sequencer
  import tetris_ai_pkg::*;
#(
  parameter int N_ACT    = 4,
  parameter int N_LAYERS = 4
) (
  input  wire logic                          clk_25m,
  input  wire logic                          rst,
  input  wire logic [FEAT_W-1:0]             score_i,
  input  wire logic                          score_valid_i,
  input  wire logic [N_ACT*FEAT_W-1:0]       res_i,
  input  wire logic                          mac_done_i,
  output logic                               mac_start_o,
  output logic      [$clog2(N_LAYERS)-1:0]   layer_sel_o,
  output logic                               act_valid_o,
  output logic      [FEAT_W-1:0]             act_o,
  output logic                               eval_busy_o,
  output logic                               eval_done_o,
  output logic      [N_ACT*FEAT_W-1:0]       eval_result_o
);

  localparam int CNT_W = $clog2(N_ACT);
  localparam int SEL_W = $clog2(N_LAYERS);

  seq_state_t       state_q;
  seq_state_t       state_d;
  logic             start_d;
  logic [CNT_W-1:0] in_cnt_q;
  logic             last_in;
  // activations for the layer being run
  logic [FEAT_W-1:0] act_q [N_ACT];

  // ====================
  // layer fsm
  // ====================
  always_comb begin
    state_d = state_q;
    start_d = 1'b0;
    case (state_q)
      SEQ_IDLE: begin
        if (score_valid_i) begin
          state_d = SEQ_LAYER0;
          start_d = 1'b1;
        end
      end
      SEQ_LAYER0: begin
        if (mac_done_i) begin
          state_d = SEQ_LAYER1;
          start_d = 1'b1;
        end
      end
      SEQ_LAYER1: begin
        if (mac_done_i) begin
          state_d = SEQ_LAYER2;
          start_d = 1'b1;
        end
      end
      SEQ_LAYER2: begin
        if (mac_done_i) begin
          state_d = SEQ_LAYER3;
          start_d = 1'b1;
        end
      end
      SEQ_LAYER3: begin
        // last layer, no further mac start
        if (mac_done_i) begin
          state_d = SEQ_DONE;
        end
      end
      SEQ_DONE: begin
        state_d = SEQ_IDLE;
      end
      default: begin
        state_d = SEQ_IDLE;
      end
    endcase
  end

  // layer number for the weight rule
  always_comb begin
    case (state_q)
      SEQ_LAYER1: layer_sel_o = SEL_W'(1);
      SEQ_LAYER2: layer_sel_o = SEL_W'(2);
      SEQ_LAYER3: layer_sel_o = SEL_W'(3);
      default:    layer_sel_o = '0;
    endcase
  end

  assign last_in     = act_valid_o && (in_cnt_q == CNT_W'(N_ACT - 1));
  assign act_o       = act_q[in_cnt_q];
  assign eval_busy_o = (state_q != SEQ_IDLE) && (state_q != SEQ_DONE);
  assign eval_done_o = (state_q == SEQ_DONE);

  // ====================
  // state, start pulse, streaming
  // ====================
  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      state_q     <= SEQ_IDLE;
      mac_start_o <= 1'b0;
      act_valid_o <= 1'b0;
      in_cnt_q    <= '0;
    end else begin
      state_q     <= state_d;
      mac_start_o <= start_d;
      // stream starts the cycle after mac start
      if (mac_start_o) begin
        act_valid_o <= 1'b1;
        in_cnt_q    <= '0;
      end else if (act_valid_o) begin
        in_cnt_q <= in_cnt_q + 1'b1;
        if (last_in) begin
          act_valid_o <= 1'b0;
        end
      end
    end
  end

  // activation and result storage
  always_ff @(posedge clk_25m) begin
    if (state_q == SEQ_IDLE && score_valid_i) begin
      // layer 0 sees the score on every input
      for (int i = 0; i < N_ACT; i++) begin
        act_q[i] <= score_i;
      end
    end else if (mac_done_i) begin
      for (int i = 0; i < N_ACT; i++) begin
        act_q[i] <= res_i[i*FEAT_W +: FEAT_W];
      end
    end
    if (state_q == SEQ_LAYER3 && mac_done_i) begin
      eval_result_o <= res_i;
    end
  end

endmodule

`default_nettype wire

//--- source/mac_array.sv
`timescale 1ns/10ps
`default_nettype none

module mac_array
  import tetris_ai_pkg::*;
#(
  parameter int N_ACT    = 4,
  parameter int N_LAYERS = 4
) (
  input  wire logic                        clk_25m,
  input  wire logic                        rst,
  input  wire logic                        mac_start_i,
  input  wire logic [$clog2(N_LAYERS)-1:0] layer_sel_i,
  input  wire logic                        act_valid_i,
  input  wire logic [FEAT_W-1:0]           act_i,
  output logic      [N_ACT*FEAT_W-1:0]     res_o,
  output logic                             mac_done_o
);

  localparam int IDX_W = $clog2(N_ACT);
  localparam int SEL_W = $clog2(N_LAYERS);
  // weights run 1..4
  localparam int WGT_W = 3;

  logic [ACC_W-1:0]  acc_q   [N_ACT];
  logic [ACC_W-1:0]  acc_d   [N_ACT];
  logic [FEAT_W-1:0] trunc_d [N_ACT];
  logic [IDX_W-1:0]  idx_q;
  logic              last_act;

  // w(l,i,j) = ((l + i + 2j) mod 4) + 1
  function automatic logic [WGT_W-1:0] rule_weight(input logic [SEL_W-1:0] layer,
                                                   input logic [IDX_W-1:0] idx,
                                                   input int col);
    int sum;
    sum = int'(layer) + int'(idx) + 2 * col;
    return WGT_W'((sum % 4) + 1);
  endfunction

  // ====================
  // per-output multiply-add
  // ====================
  always_comb begin
    logic [ACC_W-1:0] prod;
    logic [ACC_W-1:0] shifted;
    for (int j = 0; j < N_ACT; j++) begin
      prod       = ACC_W'(act_i) * ACC_W'(rule_weight(layer_sel_i, idx_q, j));
      acc_d[j]   = acc_q[j] + prod;
      // scale down, keep low byte
      shifted    = acc_d[j] >> WEIGHT_SHIFT;
      trunc_d[j] = shifted[FEAT_W-1:0];
    end
  end

  assign last_act = act_valid_i && !mac_start_i && (idx_q == IDX_W'(N_ACT - 1));

  // input index and done pulse
  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      idx_q      <= '0;
      mac_done_o <= 1'b0;
    end else begin
      mac_done_o <= last_act;
      if (mac_start_i) begin
        idx_q <= '0;
      end else if (act_valid_i) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // accumulators, cleared by start
  always_ff @(posedge clk_25m) begin
    if (mac_start_i) begin
      for (int j = 0; j < N_ACT; j++) begin
        acc_q[j] <= '0;
      end
    end else if (act_valid_i) begin
      for (int j = 0; j < N_ACT; j++) begin
        acc_q[j] <= acc_d[j];
      end
    end
    // final sums land with the done pulse
    if (last_act) begin
      for (int j = 0; j < N_ACT; j++) begin
        res_o[j*FEAT_W +: FEAT_W] <= trunc_d[j];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/tetris_ai_top.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_ai_top
  import tetris_ai_pkg::*;
(
  input  wire logic              clk_25m,
  input  wire logic              rst,
  input  wire game_state_t       gamestate_i,
  input  wire logic              start_ai_i,
  input  wire logic              start_human_i,
  input  wire logic              btn_right_i,
  input  wire logic              btn_left_i,
  input  wire logic              btn_rot_r_i,
  input  wire logic              btn_rot_l_i,
  input  wire logic              btn_fast_i,
  input  wire logic              ai_right_i,
  input  wire logic              ai_left_i,
  input  wire logic              ai_rotate_i,
  output logic                   move_right_o,
  output logic                   move_left_o,
  output logic                   rot_r_o,
  output logic                   rot_l_o,
  output logic                   speed_up_o,
  output play_mode_t             play_mode_o,
  input  wire logic              extract_ready_i,
  input  wire logic [FEAT_W-1:0] lines_cleared_i,
  input  wire logic [FEAT_W-1:0] holes_i,
  input  wire logic [FEAT_W-1:0] bumpiness_i,
  input  wire logic [FEAT_W-1:0] height_sum_i,
  output logic                   eval_busy_o,
  output logic                   eval_done_o,
  output logic [N_ACT*FEAT_W-1:0] eval_result_o
);

  // score path
  logic [FEAT_W-1:0] score;
  logic              score_valid;
  // sequencer and mac handshake
  logic                        mac_start;
  logic [$clog2(N_LAYERS)-1:0] layer_sel;
  logic                        act_valid;
  logic [FEAT_W-1:0]           act;
  logic [N_ACT*FEAT_W-1:0]     res;
  logic                        mac_done;

  // ====================
  // play mode control
  // ====================
  play_mode_arbiter u_arbiter (
    .clk_25m       (clk_25m),
    .rst           (rst),
    .gamestate_i   (gamestate_i),
    .start_ai_i    (start_ai_i),
    .start_human_i (start_human_i),
    .btn_right_i   (btn_right_i),
    .btn_left_i    (btn_left_i),
    .btn_rot_r_i   (btn_rot_r_i),
    .btn_rot_l_i   (btn_rot_l_i),
    .btn_fast_i    (btn_fast_i),
    .ai_right_i    (ai_right_i),
    .ai_left_i     (ai_left_i),
    .ai_rotate_i   (ai_rotate_i),
    .move_right_o  (move_right_o),
    .move_left_o   (move_left_o),
    .rot_r_o       (rot_r_o),
    .rot_l_o       (rot_l_o),
    .speed_up_o    (speed_up_o),
    .play_mode_o   (play_mode_o)
  );

  // ====================
  // board evaluation chain
  // ====================
  feature_scorer u_scorer (
    .clk_25m         (clk_25m),
    .rst             (rst),
    .extract_ready_i (extract_ready_i),
    .lines_cleared_i (lines_cleared_i),
    .holes_i         (holes_i),
    .bumpiness_i     (bumpiness_i),
    .height_sum_i    (height_sum_i),
    .score_o         (score),
    .score_valid_o   (score_valid)
  );

  layer_sequencer #(
    .N_ACT    (N_ACT),
    .N_LAYERS (N_LAYERS)
  ) u_sequencer (
    .clk_25m       (clk_25m),
    .rst           (rst),
    .score_i       (score),
    .score_valid_i (score_valid),
    .res_i         (res),
    .mac_done_i    (mac_done),
    .mac_start_o   (mac_start),
    .layer_sel_o   (layer_sel),
    .act_valid_o   (act_valid),
    .act_o         (act),
    .eval_busy_o   (eval_busy_o),
    .eval_done_o   (eval_done_o),
    .eval_result_o (eval_result_o)
  );

  mac_array #(
    .N_ACT    (N_ACT),
    .N_LAYERS (N_LAYERS)
  ) u_mac (
    .clk_25m     (clk_25m),
    .rst         (rst),
    .mac_start_i (mac_start),
    .layer_sel_i (layer_sel),
    .act_valid_i (act_valid),
    .act_i       (act),
    .res_o       (res),
    .mac_done_o  (mac_done)
  );

endmodule

`default_nettype wire

//--- verif/tetris_ai_tb.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_ai_tb
  import tetris_ai_pkg::*;
;

  localparam int DRIVE_DLY    = 2;
  localparam int SETTLE_DLY   = 5;
  localparam int EVAL_TIMEOUT = 200;
  localparam int QUIET_CYCLES = 80;

  logic        clk_25m;
  logic        rst;
  game_state_t gamestate_i;
  logic        start_ai_i;
  logic        start_human_i;
  logic        btn_right_i;
  logic        btn_left_i;
  logic        btn_rot_r_i;
  logic        btn_rot_l_i;
  logic        btn_fast_i;
  logic        ai_right_i;
  logic        ai_left_i;
  logic        ai_rotate_i;
  logic        move_right_o;
  logic        move_left_o;
  logic        rot_r_o;
  logic        rot_l_o;
  logic        speed_up_o;
  play_mode_t  play_mode_o;
  logic        extract_ready_i;
  logic [7:0]  lines_cleared_i;
  logic [7:0]  holes_i;
  logic [7:0]  bumpiness_i;
  logic [7:0]  height_sum_i;
  logic        eval_busy_o;
  logic        eval_done_o;
  logic [31:0] eval_result_o;

  tetris_ai_top dut (.*);

  // 25 MHz clock
  always #20 clk_25m = ~clk_25m;

  // ====================
  // reference models
  // ====================
  // weighted board score divided down to its low byte
  function automatic logic [7:0] score_model(input int lines, input int holes,
                                             input int bump, input int height);
    int total;
    total = 76 * lines + 50 * height + 36 * holes + 18 * bump;
    return 8'(total / 100);
  endfunction

  // four layers of weight ((l + i + 2j) mod 4) + 1 with sum >> 2 and low byte kept
  function automatic logic [31:0] eval_model(input logic [7:0] score);
    int act [4];
    int nxt [4];
    int sum;
    logic [31:0] res;
    for (int i = 0; i < 4; i++) begin
      act[i] = int'(score);
    end
    for (int l = 0; l < 4; l++) begin
      for (int j = 0; j < 4; j++) begin
        sum = 0;
        for (int i = 0; i < 4; i++) begin
          sum = sum + act[i] * (((l + i + 2 * j) % 4) + 1);
        end
        nxt[j] = (sum >> 2) & 255;
      end
      act = nxt;
    end
    // output 0 in low byte
    for (int j = 0; j < 4; j++) begin
      res[j*8 +: 8] = 8'(act[j]);
    end
    return res;
  endfunction

  // ====================
  // helpers
  // ====================
  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk_25m);
    #DRIVE_DLY;
  endtask

  task automatic check_moves(input logic right, input logic left, input logic rot_r,
                             input logic rot_l, input logic speed);
    #SETTLE_DLY;
    check_eq("move_right_o", 32'(right), 32'(move_right_o));
    check_eq("move_left_o", 32'(left), 32'(move_left_o));
    check_eq("rot_r_o", 32'(rot_r), 32'(rot_r_o));
    check_eq("rot_l_o", 32'(rot_l), 32'(rot_l_o));
    check_eq("speed_up_o", 32'(speed), 32'(speed_up_o));
  endtask

  task automatic set_buttons(input logic [4:0] pat);
    btn_right_i = pat[0];
    btn_left_i  = pat[1];
    btn_rot_r_i = pat[2];
    btn_rot_l_i = pat[3];
    btn_fast_i  = pat[4];
  endtask

  // one-cycle extract strobe with a feature set
  task automatic strobe_features(input logic [7:0] lines, input logic [7:0] holes,
                                 input logic [7:0] bump, input logic [7:0] height);
    lines_cleared_i = lines;
    holes_i         = holes;
    bumpiness_i     = bump;
    height_sum_i    = height;
    extract_ready_i = 1'b1;
    next_cycle();
    extract_ready_i = 1'b0;
  endtask

  // busy must hold every cycle before done
  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    next_cycle();
    while (eval_done_o !== 1'b1 && cycles < EVAL_TIMEOUT) begin
      check_eq("eval_busy_o", 32'd1, 32'(eval_busy_o));
      next_cycle();
      cycles++;
    end
    if (eval_done_o !== 1'b1) begin
      $display("no done pulse arrived within %0d cycles", EVAL_TIMEOUT);
      abort_run();
    end
  endtask

  task automatic run_eval(input logic [7:0] lines, input logic [7:0] holes,
                          input logic [7:0] bump, input logic [7:0] height);
    logic [31:0] expected;
    expected = eval_model(score_model(int'(lines), int'(holes), int'(bump), int'(height)));
    strobe_features(lines, holes, bump, height);
    wait_for_done();
    check_eq("eval_busy_o", 32'd0, 32'(eval_busy_o));
    check_eq("eval_result_o", expected, eval_result_o);
    // done is a single pulse
    next_cycle();
    check_eq("eval_done_o", 32'd0, 32'(eval_done_o));
  endtask

  // ====================
  // tests
  // ====================
  task automatic test_reset_state();
    check_eq("play_mode_o", 32'(MODE_IDLE), 32'(play_mode_o));
    check_eq("eval_busy_o", 32'd0, 32'(eval_busy_o));
    check_eq("eval_done_o", 32'd0, 32'(eval_done_o));
    // idle passes only the right button
    set_buttons(5'b11111);
    ai_right_i  = 1'b1;
    ai_left_i   = 1'b1;
    ai_rotate_i = 1'b1;
    check_moves(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    next_cycle();
    set_buttons(5'b11110);
    check_moves(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    next_cycle();
    // starts ignored while game runs
    gamestate_i   = GS_RUN;
    start_human_i = 1'b1;
    next_cycle();
    start_human_i = 1'b0;
    next_cycle();
    check_eq("play_mode_o", 32'(MODE_IDLE), 32'(play_mode_o));
    set_buttons(5'b00000);
    ai_right_i  = 1'b0;
    ai_left_i   = 1'b0;
    ai_rotate_i = 1'b0;
  endtask

  task automatic test_human_play();
    logic [4:0] pat;
    gamestate_i   = GS_INIT;
    start_human_i = 1'b1;
    next_cycle();
    start_human_i = 1'b0;
    check_eq("play_mode_o", 32'(MODE_HUMAN), 32'(play_mode_o));
    gamestate_i = GS_RUN;
    // every button combination passes straight through
    for (int p = 0; p < 32; p++) begin
      pat = 5'(p);
      set_buttons(pat);
      check_moves(pat[0], pat[1], pat[2], pat[3], pat[4]);
      next_cycle();
    end
    // gameover blanks outputs and idles on the next edge
    set_buttons(5'b11111);
    gamestate_i = GS_GAMEOVER;
    check_moves(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    next_cycle();
    check_eq("play_mode_o", 32'(MODE_IDLE), 32'(play_mode_o));
    gamestate_i = GS_RUN;
    set_buttons(5'b00000);
  endtask

  task automatic test_ai_play();
    logic [2:0] pat;
    gamestate_i = GS_RESTART;
    start_ai_i  = 1'b1;
    next_cycle();
    start_ai_i = 1'b0;
    check_eq("play_mode_o", 32'(MODE_AI), 32'(play_mode_o));
    gamestate_i = GS_RUN;
    // human buttons opposite to the engine requests
    for (int p = 0; p < 8; p++) begin
      pat         = 3'(p);
      ai_right_i  = pat[0];
      ai_left_i   = pat[1];
      ai_rotate_i = pat[2];
      set_buttons({1'b0, 1'b1, ~pat[2], ~pat[1], ~pat[0]});
      check_moves(pat[0], pat[1], pat[2], 1'b0, 1'b1);
      next_cycle();
    end
    gamestate_i = GS_GAMEOVER;
    check_moves(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    next_cycle();
    check_eq("play_mode_o", 32'(MODE_IDLE), 32'(play_mode_o));
    // ai wins when both starts are high
    gamestate_i   = GS_INIT;
    start_ai_i    = 1'b1;
    start_human_i = 1'b1;
    next_cycle();
    start_ai_i    = 1'b0;
    start_human_i = 1'b0;
    check_eq("play_mode_o", 32'(MODE_AI), 32'(play_mode_o));
    gamestate_i = GS_GAMEOVER;
    next_cycle();
    check_eq("play_mode_o", 32'(MODE_IDLE), 32'(play_mode_o));
    gamestate_i = GS_RUN;
    set_buttons(5'b00000);
    ai_right_i  = 1'b0;
    ai_left_i   = 1'b0;
    ai_rotate_i = 1'b0;
  endtask

  task automatic test_directed_eval();
    run_eval(8'd0, 8'd0, 8'd0, 8'd0);
    run_eval(8'd1, 8'd0, 8'd0, 8'd0);
    run_eval(8'd255, 8'd255, 8'd255, 8'd255);
    // mid-range board
    run_eval(8'd3, 8'd2, 8'd5, 8'd40);
  endtask

  task automatic test_random_eval();
    for (int n = 0; n < 20; n++) begin
      run_eval(8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom));
    end
  endtask

  task automatic test_no_restart();
    logic [31:0] expected;
    expected = eval_model(score_model(2, 3, 4, 50));
    strobe_features(8'd2, 8'd3, 8'd4, 8'd50);
    next_cycle();
    next_cycle();
    next_cycle();
    check_eq("eval_busy_o", 32'd1, 32'(eval_busy_o));
    // second set lands mid evaluation
    strobe_features(8'd255, 8'd255, 8'd255, 8'd255);
    wait_for_done();
    check_eq("eval_result_o", expected, eval_result_o);
    // no second evaluation may follow
    for (int c = 0; c < QUIET_CYCLES; c++) begin
      next_cycle();
      check_eq("eval_done_o", 32'd0, 32'(eval_done_o));
      check_eq("eval_busy_o", 32'd0, 32'(eval_busy_o));
    end
    check_eq("eval_result_o", expected, eval_result_o);
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    void'($urandom(32'hefd4));
    clk_25m         = 1'b0;
    rst             = 1'b1;
    gamestate_i     = GS_RUN;
    start_ai_i      = 1'b0;
    start_human_i   = 1'b0;
    set_buttons(5'b00000);
    ai_right_i      = 1'b0;
    ai_left_i       = 1'b0;
    ai_rotate_i     = 1'b0;
    extract_ready_i = 1'b0;
    lines_cleared_i = 8'd0;
    holes_i         = 8'd0;
    bumpiness_i     = 8'd0;
    height_sum_i    = 8'd0;
    repeat (10) @(posedge clk_25m);
    #DRIVE_DLY;
    rst = 1'b0;

    test_reset_state();
    test_human_play();
    test_ai_play();
    test_directed_eval();
    test_random_eval();
    test_no_restart();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tetris_ai_top.f
source/tetris_ai_pkg.sv
source/play_mode_arbiter.sv
source/feature_scorer.sv
source/layer_sequencer.sv
source/mac_array.sv
source/tetris_ai_top.sv
verif/tetris_ai_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tetris_ai testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f tetris_ai_top.f \
  --top-module tetris_ai_tb \
  -o tetris_ai_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tetris_ai_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'sim passed'; then
  exit 0
fi
exit 1
